//--- source/noc_buffer_pkg.sv
`default_nettype none

// shared widths and default sizes for the router input buffer
package noc_buffer_pkg;

    // flit control field, two bits with header above tail
    localparam int flit_ctrl_w = 2;

    // bit positions inside the control field
    localparam int hdr_bit  = 1;
    localparam int tail_bit = 0;

    // incoming flit layout, msb first:
    //   control bits | vc one-hot | payload
    // the stored word drops the vc one-hot field

    // number of virtual channels sharing one memory
    localparam int def_num_vc = 4;

    // flit slots per vc, power of two only
    localparam int def_vc_depth = 4;

    localparam int def_payload_w = 32; // data bits per flit

    // the memory holds num_vc slices of vc_depth words each,
    // addressed as {vc index, slot pointer}

endpackage

`default_nettype wire

//--- source/vc_ptr_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

// per-vc pointers and depth counters for the shared flit memory
// each vc owns one slice of vc_depth slots, the slice number is the
// upper part of the memory address and the vc pointer the lower part
module vc_ptr_ctrl #(
    parameter int num_vc   = noc_buffer_pkg::def_num_vc,
    parameter int vc_depth = noc_buffer_pkg::def_vc_depth,
    localparam int addr_w  = $clog2(num_vc * vc_depth)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [num_vc-1:0] wr,           // per-vc write strobes
    input  logic [num_vc-1:0] rd,           // per-vc read strobes
    input  logic [num_vc-1:0] wr_vc,        // one-hot, addressing only
    input  logic [num_vc-1:0] rd_vc,        // one-hot, addressing only
    output logic [addr_w-1:0] wr_addr,
    output logic [addr_w-1:0] rd_addr,
    output logic [num_vc-1:0] vc_not_empty
);

    localparam int ptr_w   = $clog2(vc_depth);
    localparam int idx_w   = addr_w - ptr_w;
    localparam int depth_w = $clog2(vc_depth + 1); // must hold vc_depth itself

    logic [ptr_w-1:0]   wr_ptr [num_vc];
    logic [ptr_w-1:0]   rd_ptr [num_vc];
    logic [depth_w-1:0] depth  [num_vc];

    logic [ptr_w-1:0] wr_ptr_sel;
    logic [ptr_w-1:0] rd_ptr_sel;
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;

    // slice math relies on the slot count being a power of two
    if (vc_depth != (2 ** ptr_w)) begin : g_depth_check
        $error("vc_ptr_ctrl: vc_depth must be a power of two");
    end

    // one-hot select to binary vc index
    // an all-zero select gives index 0, the address is then unused
    function automatic logic [idx_w-1:0] onehot_to_idx(input logic [num_vc-1:0] sel);
        logic [idx_w-1:0] idx;
        idx = '0;
        for (int i = 0; i < num_vc; i++) begin
            if (sel[i]) begin
                idx |= idx_w'(i);
            end
        end
        return idx;
    endfunction

    assign wr_idx = onehot_to_idx(wr_vc);
    assign rd_idx = onehot_to_idx(rd_vc);

    // pick the pointer of the selected vc
    always_comb begin
        wr_ptr_sel = '0;
        rd_ptr_sel = '0;
        for (int i = 0; i < num_vc; i++) begin
            if (wr_vc[i]) begin
                wr_ptr_sel |= wr_ptr[i];
            end
            if (rd_vc[i]) begin
                rd_ptr_sel |= rd_ptr[i];
            end
        end
    end

    assign wr_addr = {wr_idx, wr_ptr_sel};
    assign rd_addr = {rd_idx, rd_ptr_sel};

    for (genvar v = 0; v < num_vc; v++) begin : g_vc

        // pointers wrap on their own at vc_depth
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
            end else begin
                if (wr[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + ptr_w'(1);
                end
                if (rd[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + ptr_w'(1);
                end
            end
        end

        // read and write together leave the depth alone
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                depth[v] <= '0;
            end else if (wr[v] && !rd[v]) begin
                depth[v] <= depth[v] + depth_w'(1);
            end else if (rd[v] && !wr[v]) begin
                depth[v] <= depth[v] - depth_w'(1);
            end
        end

        assign vc_not_empty[v] = (depth[v] != '0); // goes back to the allocators

    end

endmodule

`default_nettype wire

//--- source/flit_ram.sv
`timescale 1ns/1ns
`default_nettype none

// shared flit storage for all vcs
// one write port, one read port with an output register
module flit_ram #(
    parameter int addr_w = 4,
    parameter int data_w = noc_buffer_pkg::flit_ctrl_w + noc_buffer_pkg::def_payload_w
) (
    input  logic              clk,
    input  logic              reset,     // clears the read register only
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [data_w-1:0] wr_data,
    input  logic              rd_en,
    input  logic [addr_w-1:0] rd_addr,
    output logic [data_w-1:0] rd_data
);

    localparam int words = 2 ** addr_w;

    logic [data_w-1:0] mem [words];
    logic [data_w-1:0] rd_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // same-address read and write returns the old word, no bypass
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_q <= '0;
        end else if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    // holds the last read word until the next read
    assign rd_data = rd_q;

endmodule

`default_nettype wire

//--- source/flit_buffer.sv
`timescale 1ns/1ns
`default_nettype none

// router input-port buffer
// all vcs share one flit memory, each vc has a fixed slice of it
module flit_buffer #(
    parameter int num_vc    = noc_buffer_pkg::def_num_vc,
    parameter int vc_depth  = noc_buffer_pkg::def_vc_depth,
    parameter int payload_w = noc_buffer_pkg::def_payload_w
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [noc_buffer_pkg::flit_ctrl_w+num_vc+payload_w-1:0] din,
    input  logic                                                  wr_en,
    input  logic [num_vc-1:0]                                     vc_num_wr,
    input  logic                                                  rd_en,
    input  logic [num_vc-1:0]                                     vc_num_rd,
    output logic [noc_buffer_pkg::flit_ctrl_w+payload_w-1:0]      dout,
    output logic [num_vc-1:0]                                     vc_not_empty
);

    import noc_buffer_pkg::*;

    localparam int flit_w = flit_ctrl_w + num_vc + payload_w;
    localparam int addr_w = $clog2(num_vc * vc_depth);
    localparam int data_w = flit_ctrl_w + payload_w; // vc field not stored

    logic [num_vc-1:0] wr;
    logic [num_vc-1:0] rd;
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] ram_din;
    logic [data_w-1:0] ram_dout;

    // keep header/tail and payload, drop the vc one-hot in between
    assign ram_din = {din[flit_w-1 -: flit_ctrl_w], din[payload_w-1:0]};

    // enables turn the one-hot selects into per-vc strobes
    assign wr = {num_vc{wr_en}} & vc_num_wr;
    assign rd = {num_vc{rd_en}} & vc_num_rd;

    vc_ptr_ctrl #(
        .num_vc   (num_vc),
        .vc_depth (vc_depth)
    ) u_vc_ptr_ctrl (
        .clk          (clk),
        .reset        (reset),
        .wr           (wr),
        .rd           (rd),
        .wr_vc        (vc_num_wr),
        .rd_vc        (vc_num_rd),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // port enables follow the strobes, so a stray enable
    // with an empty select does nothing
    flit_ram #(
        .addr_w (addr_w),
        .data_w (data_w)
    ) u_flit_ram (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (|wr),
        .wr_addr (wr_addr),
        .wr_data (ram_din),
        .rd_en   (|rd),
        .rd_addr (rd_addr),
        .rd_data (ram_dout)
    );

    assign dout = ram_dout; // registered in the memory, one cycle after rd_en

endmodule

`default_nettype wire

//--- tests/flit_buffer_asserts.sv
`timescale 1ns/1ns
`default_nettype none

// input rules and depth limits of the router input buffer
module flit_buffer_asserts #(
    parameter int num_vc    = noc_buffer_pkg::def_num_vc,
    parameter int vc_depth  = noc_buffer_pkg::def_vc_depth,
    parameter int payload_w = noc_buffer_pkg::def_payload_w
) (
    input logic                                             clk,
    input logic                                             reset,
    input logic                                             wr_en,
    input logic [num_vc-1:0]                                vc_num_wr,
    input logic                                             rd_en,
    input logic [num_vc-1:0]                                vc_num_rd,
    input logic [noc_buffer_pkg::flit_ctrl_w+payload_w-1:0] dout,
    input logic [num_vc-1:0]                                vc_not_empty
);

    int                fail_count = 0;
    int                fill [num_vc]; // flits held per vc, seen from the ports
    logic [num_vc-1:0] full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < num_vc; v++) begin
                fill[v] <= 0;
            end
        end else begin
            for (int v = 0; v < num_vc; v++) begin
                fill[v] <= fill[v] + int'(wr_en && vc_num_wr[v]) - int'(rd_en && vc_num_rd[v]);
            end
        end
    end

    always_comb begin
        for (int v = 0; v < num_vc; v++) begin
            full[v] = (fill[v] >= vc_depth);
        end
    end

    a_wr_onehot: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> $onehot(vc_num_wr))
        else begin
            fail_count++;
            $error("write select is not one-hot");
        end

    a_rd_onehot: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> $onehot(vc_num_rd))
        else begin
            fail_count++;
            $error("read select is not one-hot");
        end

    // a full vc takes a write only together with its own read
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (wr_en && |(vc_num_wr & full)) |-> (rd_en && vc_num_rd == vc_num_wr))
        else begin
            fail_count++;
            $error("write to a full vc without a read of the same vc");
        end

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> |(vc_num_rd & vc_not_empty))
        else begin
            fail_count++;
            $error("read of an empty vc");
        end

    a_dout_known: assert property (@(posedge clk) disable iff (reset)
        rd_en |=> !$isunknown(dout))
        else begin
            fail_count++;
            $error("dout has unknown bits after a read");
        end

endmodule

bind flit_buffer flit_buffer_asserts #(
    .num_vc    (num_vc),
    .vc_depth  (vc_depth),
    .payload_w (payload_w)
) u_flit_buffer_asserts (
    .clk          (clk),
    .reset        (reset),
    .wr_en        (wr_en),
    .vc_num_wr    (vc_num_wr),
    .rd_en        (rd_en),
    .vc_num_rd    (vc_num_rd),
    .dout         (dout),
    .vc_not_empty (vc_not_empty)
);

`default_nettype wire

//--- tests/tb_flit_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_flit_buffer;

    import noc_buffer_pkg::*;

    localparam int num_vc        = def_num_vc;
    localparam int vc_depth      = def_vc_depth;
    localparam int payload_w     = def_payload_w;
    localparam int din_w         = flit_ctrl_w + num_vc + payload_w;
    localparam int dout_w        = flit_ctrl_w + payload_w;
    localparam int period        = 40;
    localparam int reset_cycles  = 5;
    localparam int random_cycles = 600;
    // fill, drain, random traffic and idle cycles around them
    localparam int stim_cycles   = 2 * num_vc * vc_depth + random_cycles + 16;

    logic              clk;
    logic              reset;
    logic [din_w-1:0]  din;
    logic              wr_en;
    logic [num_vc-1:0] vc_num_wr;
    logic              rd_en;
    logic [num_vc-1:0] vc_num_rd;
    logic [dout_w-1:0] dout;
    logic [num_vc-1:0] vc_not_empty;

    logic [dout_w-1:0] exp_q [num_vc][$]; // expected flits, oldest first
    logic [dout_w-1:0] exp_dout;
    logic [num_vc-1:0] exp_not_empty;
    logic [dout_w-1:0] wr_flit;           // drawn control bits and payload of din
    int                cnt [num_vc];      // flits per vc as driven so far
    int                errors = 0;
    int                chk_fails;

    flit_buffer #(
        .num_vc    (num_vc),
        .vc_depth  (vc_depth),
        .payload_w (payload_w)
    ) u_flit_buffer (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    always #(period / 2) clk = ~clk;

    function automatic int vc_index(input logic [num_vc-1:0] sel);
        int idx;
        idx = 0;
        for (int i = 0; i < num_vc; i++) begin
            if (sel[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic int total_flits();
        int sum;
        sum = 0;
        for (int v = 0; v < num_vc; v++) begin
            sum += cnt[v];
        end
        return sum;
    endfunction

    // random vc that holds at least one flit
    function automatic int pick_nonempty();
        int v;
        v = $urandom_range(num_vc - 1);
        while (cnt[v] == 0) begin
            v = (v + 1) % num_vc;
        end
        return v;
    endfunction

    task automatic drive_cycle(input bit do_wr, input int wvc, input bit do_rd, input int rvc);
        logic [flit_ctrl_w-1:0] ctrl;
        logic [payload_w-1:0]   payload;
        ctrl           = '0;
        ctrl[hdr_bit]  = 1'($urandom_range(1));
        ctrl[tail_bit] = 1'($urandom_range(1));
        payload        = payload_w'($urandom);
        @(posedge clk);
        wr_en     <= do_wr;
        vc_num_wr <= do_wr ? num_vc'(1 << wvc) : '0;
        din       <= {ctrl, num_vc'(1 << wvc), payload};
        wr_flit   <= {ctrl, payload}; // vc one-hot is not part of the stored flit
        rd_en     <= do_rd;
        vc_num_rd <= do_rd ? num_vc'(1 << rvc) : '0;
        if (do_wr) begin
            cnt[wvc]++;
        end
        if (do_rd) begin
            cnt[rvc]--;
        end
    endtask

    // model sees the same inputs the dut samples on this edge
    always @(posedge clk or posedge reset) begin : model
        logic [num_vc-1:0] ne;
        if (reset) begin
            for (int v = 0; v < num_vc; v++) begin
                exp_q[v].delete();
            end
            exp_dout      <= '0;
            exp_not_empty <= '0;
        end else begin
            if (rd_en) begin
                exp_dout <= exp_q[vc_index(vc_num_rd)].pop_front();
            end
            if (wr_en) begin
                exp_q[vc_index(vc_num_wr)].push_back(wr_flit);
            end
            for (int v = 0; v < num_vc; v++) begin
                ne[v] = (exp_q[v].size() != 0);
            end
            exp_not_empty <= ne;
        end
    end

    a_dout: assert property (@(posedge clk) disable iff (reset) dout == exp_dout)
        else begin
            errors++;
            $display("MISMATCH time %0t signal dout expected %h actual %h",
                     $time, $sampled(exp_dout), $sampled(dout));
        end

    a_not_empty: assert property (@(posedge clk) disable iff (reset)
        vc_not_empty == exp_not_empty)
        else begin
            errors++;
            $display("MISMATCH time %0t signal vc_not_empty expected %b actual %b",
                     $time, $sampled(exp_not_empty), $sampled(vc_not_empty));
        end

    initial begin
        #(stim_cycles * period * 2 + reset_cycles * period);
        $display("timeout: the stimulus did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        bit do_wr;
        bit do_rd;
        int wvc;
        int rvc;
        void'($urandom(93283));
        clk       = 1'b0;
        reset     = 1'b1;
        din       = '0;
        wr_flit   = '0;
        wr_en     = 1'b0;
        vc_num_wr = '0;
        rd_en     = 1'b0;
        vc_num_rd = '0;
        for (int v = 0; v < num_vc; v++) begin
            cnt[v] = 0;
        end
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        repeat (4) drive_cycle(0, 0, 0, 0); // outputs stay clear while idle

        // interleaved fill of every vc up to vc_depth
        for (int s = 0; s < vc_depth; s++) begin
            for (int v = 0; v < num_vc; v++) begin
                drive_cycle(1, v, 0, 0);
            end
        end
        while (total_flits() > 0) begin
            drive_cycle(0, 0, 1, pick_nonempty()); // drain in random vc order
        end

        // random traffic under the credit rule
        repeat (random_cycles) begin
            do_rd = (total_flits() > 0) && ($urandom_range(1) == 1);
            rvc   = do_rd ? pick_nonempty() : 0;
            wvc   = $urandom_range(num_vc - 1);
            if (do_rd && $urandom_range(3) == 0) begin
                wvc = rvc; // same vc read and written together
            end
            do_wr = ($urandom_range(9) < 6) && (cnt[wvc] < vc_depth || (do_rd && rvc == wvc));
            drive_cycle(do_wr, wvc, do_rd, rvc);
        end
        repeat (3) drive_cycle(0, 0, 0, 0);
        @(posedge clk);
        #1;

        chk_fails = u_flit_buffer.u_flit_buffer_asserts.fail_count;
        $display("done: %0d mismatch errors, %0d protocol assertion failures",
                 errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
source/noc_buffer_pkg.sv
source/vc_ptr_ctrl.sv
source/flit_ram.sv
source/flit_buffer.sv
tests/flit_buffer_asserts.sv
tests/tb_flit_buffer.sv
